/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_spart_system
FILELIST  := build.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
source/spart_pkg.sv
source/spart_baud_gen.sv
source/spart_rx.sv
source/spart_tx.sv
source/spart.sv
source/spart_driver.sv
source/spart_system.sv
tb/tb_clkgen.sv
tb/tb_spart_system.sv

/* source/spart.sv */
`timescale 1ns/1ps

module spart (
   input  logic                  clk,
   input  logic                  rst_n,
   input  spart_pkg::spart_req_t req_i,
   output logic [7:0]            rdata_o,
   output logic                  rda_o,
   output logic                  tbr_o,
   input  logic                  rxd_i,
   output logic                  txd_o
);

   logic       wr_data;
   logic       rd_data;
   logic       wr_div_lo;
   logic       wr_div_hi;
   logic [7:0] div_lo_q;
   logic [7:0] div_hi_q;
   logic       restart_q;
   logic       tick;
   logic [7:0] rx_data;
   logic       rda;
   logic       tbr;

   //////////////////////////////
   // register decode
   //////////////////////////////

   assign wr_data   = req_i.valid && !req_i.iorw && (req_i.ioaddr == spart_pkg::ADDR_DATA);
   assign rd_data   = req_i.valid && req_i.iorw && (req_i.ioaddr == spart_pkg::ADDR_DATA);
   assign wr_div_lo = req_i.valid && !req_i.iorw && (req_i.ioaddr == spart_pkg::ADDR_DIV_LO);
   assign wr_div_hi = req_i.valid && !req_i.iorw && (req_i.ioaddr == spart_pkg::ADDR_DIV_HI);

   // status has tbr in bit 1, rda in bit 0
   assign rdata_o = (req_i.ioaddr == spart_pkg::ADDR_STATUS) ? {6'b0, tbr, rda} : rx_data;

   // divisor comes up at the slowest table entry
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         div_lo_q  <= spart_pkg::BAUD_DIV_TABLE[0][7:0];
         div_hi_q  <= spart_pkg::BAUD_DIV_TABLE[0][15:8];
         restart_q <= 1'b0;
      end
      else
      begin
         if (wr_div_lo)
         begin
            div_lo_q <= req_i.wdata;
         end
         if (wr_div_hi)
         begin
            div_hi_q <= req_i.wdata;
         end
         // restart a cycle later, once both halves hold the new value
         restart_q <= wr_div_hi;
      end
   end

   //////////////////////////////
   // datapath blocks
   //////////////////////////////

   spart_baud_gen baud_gen_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .div_i     ({div_hi_q, div_lo_q}),
      .restart_i (restart_q),
      .tick_o    (tick)
   );

   spart_rx rx_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .tick_i (tick),
      .rxd_i  (rxd_i),
      .rd_i   (rd_data),
      .data_o (rx_data),
      .rda_o  (rda)
   );

   spart_tx tx_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .tick_i (tick),
      .load_i (wr_data),
      .data_i (req_i.wdata),
      .txd_o  (txd_o),
      .tbr_o  (tbr)
   );

   assign rda_o = rda;
   assign tbr_o = tbr;

endmodule

/* source/spart_baud_gen.sv */
`timescale 1ns/1ps

module spart_baud_gen (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [spart_pkg::DIV_W-1:0] div_i,
   input  logic                        restart_i,
   output logic                        tick_o
);

   // down counter, one tick every div_i clocks
   logic [spart_pkg::DIV_W-1:0] cnt_q;
   logic [spart_pkg::DIV_W-1:0] reload;

   // count runs div_i-1 down to 0
   assign reload = div_i - 1'b1;

   // no tick in a restart cycle, counter starts over
   assign tick_o = (cnt_q == '0) && !restart_i;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt_q <= '0;
      end
      else if (restart_i)
      begin
         // new divisor takes effect from here
         cnt_q <= reload;
      end
      else if (cnt_q == '0)
      begin
         cnt_q <= reload;
      end
      else
      begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

endmodule

/* source/spart_driver.sv */
`timescale 1ns/1ps

module spart_driver (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [1:0]                       br_cfg_i,
   input  logic [7:0]                       rdata_i,
   input  logic                             rda_i,
   input  logic                             tbr_i,
   output spart_pkg::spart_req_t            req_o,
   output logic                             mem_we_o,
   output logic [spart_pkg::MEM_ADDR_W-1:0] mem_addr_o,
   output logic [spart_pkg::MEM_DATA_W-1:0] mem_wdata_o
);

   typedef enum logic [1:0] {ST_IDLE, ST_ECHO, ST_DIV_LO, ST_DIV_HI} drv_state_t;

   drv_state_t                   state_q;
   drv_state_t                   state_d;
   // baud select that was last loaded
   logic [1:0]                   cfg_q;
   logic                         cfg_load;
   logic                         rd_byte;
   logic [spart_pkg::SLOT_W-1:0] slot_q;
   logic                         is_cmd_slot;
   // slot 0 sits in the top byte of the packed vector
   logic [0:spart_pkg::FRAME_DIGITS-1][7:0] digit_q;
   logic [7:0]                   cmd_q;
   logic [7:0]                   echo_q;
   logic [7:0]                   conv_byte;
   logic [spart_pkg::DIV_W-1:0]  div_new;
   logic [spart_pkg::DIV_W-1:0]  div_cur;

   assign div_new     = spart_pkg::BAUD_DIV_TABLE[br_cfg_i];
   assign div_cur     = spart_pkg::BAUD_DIV_TABLE[cfg_q];
   assign is_cmd_slot = (slot_q == spart_pkg::CMD_SLOT);
   // ascii digit to its value, wraps for non-digits
   assign conv_byte   = rdata_i - spart_pkg::ASCII_ZERO;

   //////////////////////////////
   // control FSM
   //////////////////////////////

   always_comb
   begin
      state_d      = state_q;
      cfg_load     = 1'b0;
      rd_byte      = 1'b0;
      // idle bus points at status
      req_o.valid  = 1'b0;
      req_o.iorw   = 1'b1;
      req_o.ioaddr = spart_pkg::ADDR_STATUS;
      req_o.wdata  = 8'h00;
      case (state_q)
         ST_IDLE:
         begin
            if (br_cfg_i != cfg_q)
            begin
               // baud change beats a waiting byte
               state_d = ST_DIV_LO;
            end
            else if (rda_i)
            begin
               req_o.valid  = 1'b1;
               req_o.ioaddr = spart_pkg::ADDR_DATA;
               rd_byte      = 1'b1;
               state_d      = ST_ECHO;
            end
         end
         ST_ECHO:
         begin
            // hold until the transmitter is free
            if (tbr_i)
            begin
               req_o.valid  = 1'b1;
               req_o.iorw   = 1'b0;
               req_o.ioaddr = spart_pkg::ADDR_DATA;
               req_o.wdata  = echo_q;
               state_d      = ST_IDLE;
            end
         end
         ST_DIV_LO:
         begin
            req_o.valid  = 1'b1;
            req_o.iorw   = 1'b0;
            req_o.ioaddr = spart_pkg::ADDR_DIV_LO;
            req_o.wdata  = div_new[7:0];
            cfg_load     = 1'b1;
            state_d      = ST_DIV_HI;
         end
         default:
         begin
            // high half from the stored select so both halves match
            req_o.valid  = 1'b1;
            req_o.iorw   = 1'b0;
            req_o.ioaddr = spart_pkg::ADDR_DIV_HI;
            req_o.wdata  = div_cur[15:8];
            state_d      = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         // divisor goes out right after reset
         state_q <= ST_DIV_LO;
         cfg_q   <= 2'b00;
         slot_q  <= '0;
         cmd_q   <= 8'h00;
      end
      else
      begin
         state_q <= state_d;
         if (cfg_load)
         begin
            cfg_q <= br_cfg_i;
         end
         if (rd_byte)
         begin
            // wrap after the command slot
            slot_q <= is_cmd_slot ? '0 : slot_q + 1'b1;
         end
         // store command lives one cycle only
         if (mem_we_o)
         begin
            cmd_q <= 8'h00;
         end
         else if (rd_byte && is_cmd_slot)
         begin
            cmd_q <= rdata_i;
         end
      end
   end

   //////////////////////////////
   // frame buffer
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rd_byte && !is_cmd_slot)
      begin
         digit_q[slot_q[spart_pkg::DIGIT_W-1:0]] <= conv_byte;
      end
      // command echoes raw, digits converted
      if (rd_byte)
      begin
         echo_q <= is_cmd_slot ? rdata_i : conv_byte;
      end
   end

   // memory write port
   assign mem_we_o    = (cmd_q == spart_pkg::CMD_STORE);
   assign mem_addr_o  = spart_pkg::LAST_SLOT_ADDR;
   assign mem_wdata_o = digit_q;

endmodule

/* source/spart_pkg.sv */
package spart_pkg;

   //////////////////////////////
   // bus request from the driver
   //////////////////////////////

   // one request, acts only while valid is high
   typedef struct packed {
      logic       valid;
      // 1 for read, 0 for write
      logic       iorw;
      logic [1:0] ioaddr;
      logic [7:0] wdata;
   } spart_req_t;

   // register map
   localparam logic [1:0] ADDR_DATA   = 2'b00;
   localparam logic [1:0] ADDR_STATUS = 2'b01;
   localparam logic [1:0] ADDR_DIV_LO = 2'b10;
   localparam logic [1:0] ADDR_DIV_HI = 2'b11;

   //////////////////////////////
   // baud and bit timing
   //////////////////////////////

   localparam int DIV_W = 16;
   // indexed by baud select, short divisors keep simulation quick
   localparam logic [3:0][DIV_W-1:0] BAUD_DIV_TABLE = {16'd16, 16'd24, 16'd40, 16'd64};

   localparam int OVERSAMPLE = 16;
   localparam int TICK_W = $clog2(OVERSAMPLE);
   localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(OVERSAMPLE / 2 - 1);
   localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);

   // start, eight data bits, stop
   localparam int TX_FRAME_W = 10;
   localparam int TX_CNT_W = $clog2(TX_FRAME_W);
   localparam logic [TX_CNT_W-1:0] TX_LAST_BIT = TX_CNT_W'(TX_FRAME_W - 1);

   //////////////////////////////
   // frame and memory
   //////////////////////////////

   localparam int FRAME_DIGITS = 8;
   localparam int DIGIT_W = $clog2(FRAME_DIGITS);
   localparam int SLOT_W = DIGIT_W + 1;
   // command byte follows the last digit
   localparam logic [SLOT_W-1:0] CMD_SLOT = SLOT_W'(FRAME_DIGITS);
   localparam logic [7:0] CMD_STORE  = 8'h73;
   localparam logic [7:0] ASCII_ZERO = 8'h30;

   localparam int MEM_ADDR_W = 14;
   localparam int MEM_DATA_W = 64;
   localparam logic [MEM_ADDR_W-1:0] LAST_SLOT_ADDR = 14'h3fff;

endpackage

/* source/spart_rx.sv */
`timescale 1ns/1ps

module spart_rx (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       tick_i,
   input  logic       rxd_i,
   input  logic       rd_i,
   output logic [7:0] data_o,
   output logic       rda_o
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   logic [1:0]                   sync_q;
   logic                         rxd_s;
   rx_state_t                    state_q;
   logic [spart_pkg::TICK_W-1:0] tick_cnt_q;
   logic [2:0]                   bit_cnt_q;
   logic [7:0]                   shift_q;
   logic [7:0]                   data_q;
   logic                         rda_q;
   logic                         tick_last;
   logic                         sample_bit;
   logic                         take_byte;

   //////////////////////////////
   // input synchronizer
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         // line idles high
         sync_q <= 2'b11;
      end
      else
      begin
         sync_q <= {sync_q[0], rxd_i};
      end
   end

   assign rxd_s = sync_q[1];

   //////////////////////////////
   // bit timing FSM
   //////////////////////////////

   assign tick_last  = (tick_cnt_q == spart_pkg::TICK_LAST);
   // mid-bit of a data bit
   assign sample_bit = tick_i && (state_q == RX_DATA) && tick_last;
   // stop bit must read high or the byte is dropped
   assign take_byte  = tick_i && (state_q == RX_STOP) && tick_last && rxd_s;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q    <= RX_IDLE;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end
      else if (tick_i)
      begin
         case (state_q)
            RX_IDLE:
            begin
               // first low sample after an idle line is the start edge
               if (!rxd_s)
               begin
                  state_q    <= RX_START;
                  tick_cnt_q <= '0;
               end
            end
            RX_START:
            begin
               if (tick_cnt_q == spart_pkg::TICK_MID)
               begin
                  // still low at mid start bit, else it was a glitch
                  state_q    <= rxd_s ? RX_IDLE : RX_DATA;
                  tick_cnt_q <= '0;
                  bit_cnt_q  <= '0;
               end
               else
               begin
                  tick_cnt_q <= tick_cnt_q + 1'b1;
               end
            end
            RX_DATA:
            begin
               tick_cnt_q <= tick_cnt_q + 1'b1;
               if (tick_last)
               begin
                  bit_cnt_q <= bit_cnt_q + 1'b1;
                  if (bit_cnt_q == 3'd7)
                  begin
                     state_q <= RX_STOP;
                  end
               end
            end
            default:
            begin
               tick_cnt_q <= tick_cnt_q + 1'b1;
               if (tick_last)
               begin
                  state_q <= RX_IDLE;
               end
            end
         endcase
      end
   end

   // lsb first, shifts in from the top
   always_ff @(posedge clk)
   begin
      if (sample_bit)
      begin
         shift_q <= {rxd_s, shift_q[7:1]};
      end
      if (take_byte)
      begin
         data_q <= shift_q;
      end
   end

   // new byte wins over a read in the same cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rda_q <= 1'b0;
      end
      else if (take_byte)
      begin
         rda_q <= 1'b1;
      end
      else if (rd_i)
      begin
         rda_q <= 1'b0;
      end
   end

   assign data_o = data_q;
   assign rda_o  = rda_q;

endmodule

/* source/spart_system.sv */
`timescale 1ns/1ps

module spart_system (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [1:0]                       br_cfg_i,
   input  logic                             rxd_i,
   output logic                             txd_o,
   output logic                             mem_we_o,
   output logic [spart_pkg::MEM_ADDR_W-1:0] mem_addr_o,
   output logic [spart_pkg::MEM_DATA_W-1:0] mem_wdata_o
);

   // driver to spart bus
   spart_pkg::spart_req_t req;
   logic [7:0]            rdata;
   logic                  rda;
   logic                  tbr;

   spart_driver driver_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .br_cfg_i    (br_cfg_i),
      .rdata_i     (rdata),
      .rda_i       (rda),
      .tbr_i       (tbr),
      .req_o       (req),
      .mem_we_o    (mem_we_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o)
   );

   spart spart_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .req_i   (req),
      .rdata_o (rdata),
      .rda_o   (rda),
      .tbr_o   (tbr),
      .rxd_i   (rxd_i),
      .txd_o   (txd_o)
   );

endmodule

/* source/spart_tx.sv */
`timescale 1ns/1ps

module spart_tx (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       tick_i,
   input  logic       load_i,
   input  logic [7:0] data_i,
   output logic       txd_o,
   output logic       tbr_o
);

   logic [spart_pkg::TX_FRAME_W-1:0] shift_q;
   logic                             busy_q;
   logic [spart_pkg::TICK_W-1:0]     tick_cnt_q;
   logic [spart_pkg::TX_CNT_W-1:0]   bit_cnt_q;
   logic                             bit_end;

   // last tick of the current bit
   assign bit_end = busy_q && tick_i && (tick_cnt_q == spart_pkg::TICK_LAST);

   //////////////////////////////
   // frame shift register
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         // all ones keeps the line at idle high
         shift_q    <= '1;
         busy_q     <= 1'b0;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end
      else if (load_i && !busy_q)
      begin
         // stop, data lsb first, start in bit 0
         shift_q    <= {1'b1, data_i, 1'b0};
         busy_q     <= 1'b1;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end
      else if (busy_q && tick_i)
      begin
         tick_cnt_q <= tick_cnt_q + 1'b1;
         if (bit_end)
         begin
            // ones fill in behind, line returns high
            shift_q   <= {1'b1, shift_q[spart_pkg::TX_FRAME_W-1:1]};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == spart_pkg::TX_LAST_BIT)
            begin
               // stop bit done
               busy_q <= 1'b0;
            end
         end
      end
   end

   assign txd_o = shift_q[0];
   assign tbr_o = !busy_q;

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk_o
);

   // 100 ns period
   localparam time HALF_PERIOD = 50ns;

   initial
   begin
      clk_o = 1'b0;
   end

   always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

/* tb/tb_spart_system.sv */
`timescale 1ns/1ps

module tb_spart_system;

   localparam logic [31:0] SEED = 32'hc52e56e8;
   // inputs move this long after the rising edge
   localparam int DRV_DLY = 2;
   // start bit must show up within this many bit periods
   localparam int ECHO_LIMIT_BITS = 40;
   // every store goes to the last memory slot
   localparam logic [13:0] STORE_ADDR = 14'h3fff;

   logic                             clk;
   logic                             rst_n;
   logic [1:0]                       br_cfg_i;
   logic                             rxd_i;
   logic                             txd_o;
   logic                             mem_we_o;
   logic [spart_pkg::MEM_ADDR_W-1:0] mem_addr_o;
   logic [spart_pkg::MEM_DATA_W-1:0] mem_wdata_o;

   int          mismatch_count;
   int          timeout_count;
   // memory write pulses seen and expected
   int          store_count;
   int          exp_store_count;
   // model of the memory word, slot 0 in the top byte
   logic [63:0] exp_word;
   logic [1:0]  cur_cfg;

   tb_clkgen clkgen_inst (
      .clk_o (clk)
   );

   spart_system spart_system_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .br_cfg_i    (br_cfg_i),
      .rxd_i       (rxd_i),
      .txd_o       (txd_o),
      .mem_we_o    (mem_we_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o)
   );

   //////////////////////////////
   // model helpers
   //////////////////////////////

   // clocks per serial bit at a baud select
   function automatic int bit_clocks(input logic [1:0] cfg);
      return spart_pkg::OVERSAMPLE * int'(spart_pkg::BAUD_DIV_TABLE[cfg]);
   endfunction

   // bits the line stays low, start bit plus low data bits from the lsb up
   function automatic int low_bits(input logic [7:0] b);
      int n;
      bit run;
      n = 1;
      run = 1'b1;
      for (int i = 0; i < 8; i++)
      begin
         if (run && !b[i])
         begin
            n++;
         end
         else
         begin
            run = 1'b0;
         end
      end
      return n;
   endfunction

   // mismatch when the values differ by more than tol
   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act, input int tol);
      logic [63:0] diff;
      diff = (exp > act) ? (exp - act) : (act - exp);
      if (diff > 64'(tol))
      begin
         mismatch_count++;
         $display("Mismatch %s: expected %0h, got %0h", name, exp, act);
      end
   endtask

   //////////////////////////////
   // serial host model
   //////////////////////////////

   // start, eight data bits lsb first, stop
   task automatic send_byte(input logic [7:0] b, input logic [1:0] cfg);
      logic [9:0] frame;
      int         bitclk;
      frame = {1'b1, b, 1'b0};
      bitclk = bit_clocks(cfg);
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         #DRV_DLY;
         rxd_i = frame[i];
         repeat (bitclk - 1) @(posedge clk);
      end
   endtask

   // falling edge on txd, sampled on the falling clock
   task automatic wait_txd_low(input int limit, output bit ok);
      int n;
      n = 0;
      ok = 1'b0;
      while (n < limit && !ok)
      begin
         @(negedge clk);
         if (!txd_o)
         begin
            ok = 1'b1;
         end
         else
         begin
            n++;
         end
      end
      if (!ok)
      begin
         timeout_count++;
         $display("Timeout: no start bit on txd_o within %0d cycles", limit);
      end
   endtask

   // catch one echo, sample each bit at mid-bit and time the first low run
   task automatic capture_echo(input logic [7:0] exp_byte, input logic [1:0] cfg);
      int         bitclk;
      int         div;
      int         low_run;
      int         k;
      bit         ok;
      bit         high_seen;
      logic [7:0] got;
      logic       stop_bit;
      bitclk = bit_clocks(cfg);
      div = int'(spart_pkg::BAUD_DIV_TABLE[cfg]);
      low_run = 0;
      high_seen = 1'b0;
      got = '0;
      stop_bit = 1'b0;
      wait_txd_low(ECHO_LIMIT_BITS * bitclk, ok);
      if (ok)
      begin
         for (int n = 1; n <= 9 * bitclk + bitclk / 2; n++)
         begin
            @(negedge clk);
            if (txd_o && !high_seen)
            begin
               high_seen = 1'b1;
               low_run = n;
            end
            // mid-bit points, k is 1..8 for data, 9 for stop
            if (n >= bitclk + bitclk / 2 && (n - bitclk / 2) % bitclk == 0)
            begin
               k = (n - bitclk / 2) / bitclk;
               if (k <= 8)
               begin
                  got[k-1] = txd_o;
               end
               else
               begin
                  stop_bit = txd_o;
               end
            end
         end
         check_value("txd_o echo byte", 64'(exp_byte), 64'(got), 0);
         check_value("txd_o stop bit", 64'(1), 64'(stop_bit), 0);
         // first tick lands up to one divisor late
         check_value("txd_o low time", 64'(low_bits(exp_byte) * bitclk), 64'(low_run), div);
      end
   endtask

   // host sends while the monitor waits for the echo
   task automatic exchange_byte(input logic [7:0] sent, input logic [7:0] echo);
      fork
         send_byte(sent, cur_cfg);
         capture_echo(echo, cur_cfg);
      join
   endtask

   // one slot of a frame, digits 0..7 then the command slot
   task automatic send_slot(input int slot, input bit store);
      logic [7:0] b;
      logic [7:0] echo;
      logic [7:0] digit;
      if (slot < spart_pkg::FRAME_DIGITS)
      begin
         // ascii digit on the line, its value comes back
         digit = 8'($urandom % 10);
         b = spart_pkg::ASCII_ZERO + digit;
         echo = digit;
         exp_word[(7 - slot) * 8 +: 8] = digit;
      end
      else
      begin
         if (store)
         begin
            b = spart_pkg::CMD_STORE;
            exp_store_count++;
         end
         else
         begin
            b = 8'($urandom);
            if (b == spart_pkg::CMD_STORE)
            begin
               b = b + 8'd1;
            end
         end
         // command comes back raw
         echo = b;
      end
      exchange_byte(b, echo);
   endtask

   task automatic run_frame(input bit store);
      for (int s = 0; s <= int'(spart_pkg::CMD_SLOT); s++)
      begin
         send_slot(s, store);
      end
      check_value("mem_we_o pulses", 64'(exp_store_count), 64'(store_count), 0);
   endtask

   // let the echo stop bit finish, then switch the rate
   task automatic change_baud(input logic [1:0] cfg);
      repeat (bit_clocks(cur_cfg)) @(posedge clk);
      #DRV_DLY;
      br_cfg_i = cfg;
      cur_cfg = cfg;
      // driver needs two bus cycles for the divisor
      repeat (8) @(posedge clk);
   endtask

   //////////////////////////////
   // memory port monitor
   //////////////////////////////

   always @(negedge clk)
   begin
      if (rst_n && mem_we_o)
      begin
         store_count++;
         check_value("mem_addr_o", 64'(STORE_ADDR), 64'(mem_addr_o), 0);
         check_value("mem_wdata_o", exp_word, mem_wdata_o, 0);
      end
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial
   begin
      rst_n = 1'b0;
      br_cfg_i = 2'b00;
      rxd_i = 1'b1;
      cur_cfg = 2'b00;
      mismatch_count = 0;
      timeout_count = 0;
      store_count = 0;
      exp_store_count = 0;
      exp_word = '0;
      void'($urandom(SEED));
      repeat (2) @(posedge clk);
      #DRV_DLY;
      rst_n = 1'b1;
      repeat (8) @(posedge clk);

      // every rate, a plain frame then a store frame
      for (int c = 0; c < 4; c++)
      begin
         change_baud(2'(c));
         run_frame(1'b0);
         run_frame(1'b1);
      end

      // rate change in the middle of a frame, slot count carries on
      change_baud(2'd2);
      for (int s = 0; s < 4; s++)
      begin
         send_slot(s, 1'b1);
      end
      change_baud(2'd1);
      for (int s = 4; s <= int'(spart_pkg::CMD_SLOT); s++)
      begin
         send_slot(s, 1'b1);
      end
      check_value("mem_we_o pulses", 64'(exp_store_count), 64'(store_count), 0);

      $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
